// File: hdl/ifu_pkg.sv
/*
 * instruction fetch unit package
 * bus and instruction widths, halfword slot encoding, fetch limits and
 * the reset pc shared by every fetch block
 */
`default_nettype none

package ifu_pkg;

    // bus side
    typedef logic [63:0] addr_t;
    typedef logic [63:0] word_t;
    typedef logic [1:0]  resp_t;

    // instruction side
    typedef logic [31:0] inst_t;
    typedef logic [15:0] half_t;

    // halfword of the current word, taken from pc[2:1]
    typedef enum logic [1:0] {
        SLOT0 = 2'd0,
        SLOT1 = 2'd1,
        SLOT2 = 2'd2,
        SLOT3 = 2'd3
    } slot_e;

    localparam addr_t RESET_PC = 64'h0;

    // outstanding read limit, also the response buffer depth
    localparam int MAX_INFLIGHT = 4;

    localparam addr_t WORD_BYTES = 64'd8;

    // low bits of a 32-bit instruction
    localparam logic [1:0] FULL_OPCODE = 2'b11;

endpackage

`default_nettype wire

// File: hdl/fetch_request.sv
/*
 * fetch request side
 * drives the read address channel from the fetch pc, keeps the number of
 * reads in flight under the limit and drops beats owed from before a jump
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_request (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 jump_flag,
    input  wire ifu_pkg::addr_t jump_addr,
    input  wire                 arready,
    input  wire                 rvalid,
    input  wire                 pop,
    output logic                arvalid,
    output ifu_pkg::addr_t      araddr,
    output logic                buf_wen
);

    typedef logic [$clog2(ifu_pkg::MAX_INFLIGHT + 1) - 1:0] cnt_t;

    ifu_pkg::addr_t fetch_pc;
    cnt_t           pend_cnt;   // accepted, word not yet popped
    cnt_t           owed_cnt;   // accepted, beat not yet returned
    cnt_t           drop_cnt;   // stale beats still to come
    cnt_t           pend_next;
    cnt_t           owed_next;
    logic           accept;
    logic           below_limit;

    assign accept  = arvalid & arready;
    assign araddr  = fetch_pc;
    assign buf_wen = rvalid & (drop_cnt == '0);

    always_comb begin
        pend_next = pend_cnt;
        if (accept && !pop) begin
            pend_next = pend_cnt + cnt_t'(1);
        end else if (!accept && pop) begin
            pend_next = pend_cnt - cnt_t'(1);
        end

        owed_next = owed_cnt;
        if (accept && !rvalid) begin
            owed_next = owed_cnt + cnt_t'(1);
        end else if (!accept && rvalid) begin
            owed_next = owed_cnt - cnt_t'(1);
        end
    end

    assign below_limit = (pend_next != cnt_t'(ifu_pkg::MAX_INFLIGHT)) &&
                         (owed_next != cnt_t'(ifu_pkg::MAX_INFLIGHT));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc <= ifu_pkg::RESET_PC;
            arvalid  <= 1'b0;
            pend_cnt <= '0;
            owed_cnt <= '0;
            drop_cnt <= '0;
        end else begin
            // beats keep coming back for old requests across a jump
            owed_cnt <= owed_next;
            if (jump_flag) begin
                fetch_pc <= jump_addr & ~(ifu_pkg::WORD_BYTES - 64'd1);
                arvalid  <= 1'b0;
                pend_cnt <= '0;
                drop_cnt <= owed_next;
            end else begin
                pend_cnt <= pend_next;
                if (accept) begin
                    fetch_pc <= fetch_pc + ifu_pkg::WORD_BYTES;
                end
                // hold a pending request, else raise while under the limit
                arvalid <= (arvalid && !accept) || below_limit;
                if (rvalid && drop_cnt != '0) begin
                    drop_cnt <= drop_cnt - cnt_t'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_buffer.sv
/*
 * read response buffer
 * circular buffer of data word plus response code, flushed on a jump
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 jump_flag,
    input  wire                 wen,
    input  wire ifu_pkg::word_t wdata,
    input  wire ifu_pkg::resp_t wresp,
    input  wire                 pop,
    output ifu_pkg::word_t      head_data,
    output ifu_pkg::resp_t      head_resp,
    output logic                not_empty
);

    typedef logic [$clog2(ifu_pkg::MAX_INFLIGHT) - 1:0]     ptr_t;
    typedef logic [$clog2(ifu_pkg::MAX_INFLIGHT + 1) - 1:0] cnt_t;

    ifu_pkg::word_t data_mem [ifu_pkg::MAX_INFLIGHT];
    ifu_pkg::resp_t resp_mem [ifu_pkg::MAX_INFLIGHT];
    ptr_t           wr_ptr;
    ptr_t           rd_ptr;
    cnt_t           count;

    function automatic ptr_t ptr_inc(input ptr_t p);
        return (p == ptr_t'(ifu_pkg::MAX_INFLIGHT - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    assign head_data = data_mem[rd_ptr];
    assign head_resp = resp_mem[rd_ptr];
    assign not_empty = (count != '0);

    always_ff @(posedge clk) begin
        if (wen) begin
            data_mem[wr_ptr] <= wdata;
            resp_mem[wr_ptr] <= wresp;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (jump_flag) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wen) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (wen && !pop) begin
                count <= count + cnt_t'(1);
            end else if (!wen && pop) begin
                count <= count - cnt_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/inst_aligner.sv
/*
 * instruction aligner
 * cuts the buffered words into 16-bit and 32-bit instructions, joins an
 * instruction that crosses a word boundary, and tags pc, response and tval
 */
`timescale 1ns/1ps
`default_nettype none

module inst_aligner (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 jump_flag,
    input  wire ifu_pkg::addr_t jump_addr,
    input  wire ifu_pkg::word_t head_data,
    input  wire ifu_pkg::resp_t head_resp,
    input  wire                 not_empty,
    input  wire                 space,
    output logic                pop,
    output logic                item_valid,
    output ifu_pkg::inst_t      item_inst,
    output logic                item_compressed,
    output ifu_pkg::resp_t      item_resp,
    output ifu_pkg::addr_t      item_tval,
    output ifu_pkg::addr_t      item_pc
);

    ifu_pkg::addr_t pc_q;
    ifu_pkg::half_t left_half;   // top halfword of the last popped word
    ifu_pkg::resp_t left_resp;
    logic           left_valid;
    ifu_pkg::slot_e slot;
    ifu_pkg::inst_t window;
    logic           is_comp;
    logic           load_only;
    logic           fire;

    assign slot = ifu_pkg::slot_e'(pc_q[2:1]);

    always_comb begin
        case (slot)
            ifu_pkg::SLOT0: window = head_data[31:0];
            ifu_pkg::SLOT1: window = head_data[47:16];
            ifu_pkg::SLOT2: window = head_data[63:32];
            default:        window = {head_data[15:0], left_half};
        endcase
    end

    assign is_comp = (window[1:0] != ifu_pkg::FULL_OPCODE);

    // after a jump to offset 6 the top halfword has to be fetched first
    assign load_only = (slot == ifu_pkg::SLOT3) && !left_valid && not_empty;
    assign fire      = not_empty && space && !((slot == ifu_pkg::SLOT3) && !left_valid);

    // pop once nothing of the head word is needed past this instruction
    assign pop = load_only ||
                 (fire && ((slot == ifu_pkg::SLOT1 && !is_comp) || slot == ifu_pkg::SLOT2));

    assign item_valid      = fire;
    assign item_compressed = is_comp;
    assign item_inst       = is_comp ? {{16{1'b0}}, window[15:0]} : window;
    assign item_pc         = pc_q;

    always_comb begin
        item_resp = head_resp;
        item_tval = pc_q;
        if (slot == ifu_pkg::SLOT3) begin
            if (is_comp || left_resp != '0) begin
                item_resp = left_resp;
            end
            // fault in the second half
            if (!is_comp && left_resp == '0) begin
                item_tval = pc_q + 64'd2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            left_half <= head_data[63:48];
            left_resp <= head_resp;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q       <= ifu_pkg::RESET_PC;
            left_valid <= 1'b0;
        end else if (jump_flag) begin
            pc_q       <= jump_addr;
            left_valid <= 1'b0;
        end else begin
            if (fire) begin
                pc_q <= pc_q + (is_comp ? 64'd2 : 64'd4);
            end
            if (pop) begin
                left_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/decode_queue.sv
/*
 * decoder-side output queue
 * two ping-pong entries, handed out in arrival order over valid/ready
 */
`timescale 1ns/1ps
`default_nettype none

module decode_queue (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 jump_flag,
    input  wire                 item_valid,
    input  wire ifu_pkg::inst_t item_inst,
    input  wire                 item_compressed,
    input  wire ifu_pkg::resp_t item_resp,
    input  wire ifu_pkg::addr_t item_tval,
    input  wire ifu_pkg::addr_t item_pc,
    input  wire                 inst_ready,
    output logic                space,
    output logic                inst_valid,
    output ifu_pkg::inst_t      inst,
    output logic                compressed,
    output ifu_pkg::resp_t      rresp_out,
    output ifu_pkg::addr_t      tval,
    output ifu_pkg::addr_t      pc
);

    ifu_pkg::inst_t q_inst [2];
    logic           q_comp [2];
    ifu_pkg::resp_t q_resp [2];
    ifu_pkg::addr_t q_tval [2];
    ifu_pkg::addr_t q_pc   [2];
    logic [1:0]     q_valid;
    logic           sel;      // entry currently presented
    logic           wr_idx;
    logic           push;
    logic           deq;

    assign space  = ~(q_valid[0] & q_valid[1]);
    assign push   = item_valid & space;
    // fill the presented entry when it is free, else the other one
    assign wr_idx = q_valid[sel] ? ~sel : sel;

    assign inst_valid = q_valid[sel];
    assign deq        = inst_valid & inst_ready;

    assign inst       = q_inst[sel];
    assign compressed = q_comp[sel];
    assign rresp_out  = q_resp[sel];
    assign tval       = q_tval[sel];
    assign pc         = q_pc[sel];

    always_ff @(posedge clk) begin
        if (push) begin
            q_inst[wr_idx] <= item_inst;
            q_comp[wr_idx] <= item_compressed;
            q_resp[wr_idx] <= item_resp;
            q_tval[wr_idx] <= item_tval;
            q_pc[wr_idx]   <= item_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 2'b00;
            sel     <= 1'b0;
        end else if (jump_flag) begin
            q_valid <= 2'b00;
            sel     <= 1'b0;
        end else begin
            if (deq) begin
                q_valid[sel] <= 1'b0;
                sel          <= ~sel;
            end
            if (push) begin
                q_valid[wr_idx] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/ifu_top.sv
/*
 * instruction fetch unit top
 * request side, response buffer, aligner and decoder-side queue
 */
`timescale 1ns/1ps
`default_nettype none

module ifu_top (
    input  wire                 clk,
    input  wire                 rst_n,
    output wire ifu_pkg::addr_t araddr,
    output wire                 arvalid,
    input  wire                 arready,
    input  wire                 rvalid,
    input  wire ifu_pkg::word_t rdata,
    input  wire ifu_pkg::resp_t rresp,
    input  wire                 jump_flag,
    input  wire ifu_pkg::addr_t jump_addr,
    output wire                 inst_valid,
    input  wire                 inst_ready,
    output wire ifu_pkg::inst_t inst,
    output wire                 compressed,
    output wire ifu_pkg::resp_t rresp_out,
    output wire ifu_pkg::addr_t tval,
    output wire ifu_pkg::addr_t pc
);

    wire                 buf_wen;
    wire                 buf_pop;
    wire                 buf_not_empty;
    wire ifu_pkg::word_t head_data;
    wire ifu_pkg::resp_t head_resp;

    wire                 q_space;
    wire                 item_valid;
    wire ifu_pkg::inst_t item_inst;
    wire                 item_compressed;
    wire ifu_pkg::resp_t item_resp;
    wire ifu_pkg::addr_t item_tval;
    wire ifu_pkg::addr_t item_pc;

    fetch_request u_fetch_request (
        .clk       (clk),
        .rst_n     (rst_n),
        .jump_flag (jump_flag),
        .jump_addr (jump_addr),
        .arready   (arready),
        .rvalid    (rvalid),
        .pop       (buf_pop),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .buf_wen   (buf_wen)
    );

    fetch_buffer u_fetch_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .jump_flag (jump_flag),
        .wen       (buf_wen),
        .wdata     (rdata),
        .wresp     (rresp),
        .pop       (buf_pop),
        .head_data (head_data),
        .head_resp (head_resp),
        .not_empty (buf_not_empty)
    );

    inst_aligner u_inst_aligner (
        .clk             (clk),
        .rst_n           (rst_n),
        .jump_flag       (jump_flag),
        .jump_addr       (jump_addr),
        .head_data       (head_data),
        .head_resp       (head_resp),
        .not_empty       (buf_not_empty),
        .space           (q_space),
        .pop             (buf_pop),
        .item_valid      (item_valid),
        .item_inst       (item_inst),
        .item_compressed (item_compressed),
        .item_resp       (item_resp),
        .item_tval       (item_tval),
        .item_pc         (item_pc)
    );

    decode_queue u_decode_queue (
        .clk             (clk),
        .rst_n           (rst_n),
        .jump_flag       (jump_flag),
        .item_valid      (item_valid),
        .item_inst       (item_inst),
        .item_compressed (item_compressed),
        .item_resp       (item_resp),
        .item_tval       (item_tval),
        .item_pc         (item_pc),
        .inst_ready      (inst_ready),
        .space           (q_space),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .compressed      (compressed),
        .rresp_out       (rresp_out),
        .tval            (tval),
        .pc              (pc)
    );

endmodule

`default_nettype wire

// File: verif/ifu_assertions.sv
/*
 * fetch unit port assertions
 * address hold until accept, decoder outputs stable under back-pressure,
 * no unknown inst_valid out of reset
 */
`timescale 1ns/1ps
`default_nettype none

module ifu_assertions (
    input wire                 clk,
    input wire                 rst_n,
    input wire                 arvalid,
    input wire                 arready,
    input wire ifu_pkg::addr_t araddr,
    input wire                 jump_flag,
    input wire                 inst_valid,
    input wire                 inst_ready,
    input wire ifu_pkg::inst_t inst,
    input wire                 compressed,
    input wire ifu_pkg::resp_t rresp_out,
    input wire ifu_pkg::addr_t tval,
    input wire ifu_pkg::addr_t pc
);

    // a pending request keeps its address until accepted or redirected
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (arvalid && !arready && !jump_flag) |=> (arvalid && $stable(araddr)))
        else $error("arvalid or araddr changed before accept");

    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (inst_valid && !inst_ready && !jump_flag) |=>
        (inst_valid && $stable(inst) && $stable(compressed) && $stable(rresp_out)
         && $stable(tval) && $stable(pc)))
        else $error("decoder outputs changed under back-pressure");

    valid_known: assert property (@(posedge clk) rst_n |-> !$isunknown(inst_valid))
        else $error("inst_valid unknown after reset");

endmodule

bind ifu_top ifu_assertions u_assertions (
    .clk(clk), .rst_n(rst_n), .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .jump_flag(jump_flag), .inst_valid(inst_valid), .inst_ready(inst_ready),
    .inst(inst), .compressed(compressed), .rresp_out(rresp_out), .tval(tval), .pc(pc)
);

`default_nettype wire

// File: verif/ifu_tb.sv
/*
 * fetch unit testbench
 * memory model with variable latency, table of fetch runs, reference
 * instruction stream rebuilt from the memory hash
 */
`timescale 1ns/1ps
`default_nettype none

module ifu_tb;

    localparam int ROWS = 8;

    logic clk = 1'b0;
    logic rst_n, arready, rvalid, jump_flag, inst_ready;
    ifu_pkg::addr_t araddr, jump_addr, tval, pc;
    ifu_pkg::word_t rdata;
    ifu_pkg::resp_t rresp, rresp_out;
    ifu_pkg::inst_t inst;
    logic arvalid, inst_valid, compressed;

    // table columns: start, use reset, seek crossing, count, ready mode,
    // latency mode, error word (0 none, 1 second half, 2 first half)
    ifu_pkg::addr_t row_start [ROWS];
    logic           row_reset [ROWS];
    logic           row_seek  [ROWS];
    int             row_count [ROWS];
    logic           row_rdy   [ROWS];
    logic           row_lat   [ROWS];
    int             row_err   [ROWS];

    integer         seed = 32'h6bde_c07d;
    ifu_pkg::addr_t err_word = '1;
    logic           lat_rand = 1'b0;
    int             cyc = 0;
    int             total_err = 0;
    int             failed_tests = 0;
    ifu_pkg::addr_t mq_addr [$];
    int             mq_due [$];

    ifu_top uut (
        .clk(clk), .rst_n(rst_n), .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .jump_flag(jump_flag),
        .jump_addr(jump_addr), .inst_valid(inst_valid), .inst_ready(inst_ready),
        .inst(inst), .compressed(compressed), .rresp_out(rresp_out), .tval(tval), .pc(pc)
    );

    always #4 clk = ~clk;

    // bit 0 forced high so about half the halfwords end in 11
    function automatic ifu_pkg::half_t half_at(input ifu_pkg::addr_t a);
        logic [31:0] x;
        x = a[31:0] * 32'h9e37_79b1;
        x = x ^ (x >> 15);
        x = x * 32'h85eb_ca6b;
        return {x[31:17] ^ x[15:1], 1'b1};
    endfunction

    function automatic ifu_pkg::resp_t resp_at(input ifu_pkg::addr_t a);
        return ((a & ~64'd7) == err_word) ? 2'b10 : 2'b00;
    endfunction

    function automatic ifu_pkg::addr_t find_crossing(input ifu_pkg::addr_t a);
        ifu_pkg::addr_t p;
        ifu_pkg::half_t h;
        p = (a & ~64'd7) + 64'd6;
        h = half_at(p);
        for (int i = 0; i < 4096 && h[1:0] != 2'b11; i++) begin
            p = p + 64'd8;
            h = half_at(p);
        end
        return p;
    endfunction

    // memory model, in-order answers after 1 to 4 cycles
    always @(posedge clk) begin
        logic           serve;
        logic           ar_rdy;
        ifu_pkg::addr_t a;
        cyc++;
        serve = 1'b0;
        a = '0;
        if (!rst_n) begin
            mq_addr.delete();
            mq_due.delete();
        end else begin
            if (arvalid && arready) begin
                if (araddr[2:0] != 3'd0) begin
                    $display("ERR araddr got %h exp %h", araddr, araddr & ~64'd7);
                    total_err++;
                end
                mq_addr.push_back(araddr);
                mq_due.push_back(cyc + (lat_rand ? 1 + ($random(seed) & 3) : 2));
            end
            if (mq_addr.size() > 0 && mq_due[0] <= cyc) begin
                serve = 1'b1;
                a = mq_addr.pop_front();
                void'(mq_due.pop_front());
            end
        end
        ar_rdy = lat_rand ? (($random(seed) & 1) != 0) : 1'b1;
        #1;
        rvalid  <= serve;
        rdata   <= {half_at(a + 6), half_at(a + 4), half_at(a + 2), half_at(a)};
        rresp   <= resp_at(a);
        arready <= ar_rdy;
    end

    task automatic load_table();
        row_start = '{64'h0, 64'h0, 64'h200, 64'h402, 64'h504, 64'h606, 64'h700, 64'h900};
        row_reset = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
        row_seek  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
        row_count = '{40, 60, 20, 20, 20, 20, 24, 24};
        row_rdy   = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};
        row_lat   = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};
        row_err   = '{0, 0, 0, 0, 0, 0, 1, 2};
    endtask

    task automatic check_item(input ifu_pkg::addr_t p, inout int errs);
        ifu_pkg::half_t lo;
        ifu_pkg::inst_t e_inst;
        ifu_pkg::resp_t r1;
        ifu_pkg::resp_t r2;
        ifu_pkg::resp_t e_resp;
        ifu_pkg::addr_t e_tval;
        logic           e_comp;
        lo = half_at(p);
        e_comp = (lo[1:0] != 2'b11);
        e_inst = e_comp ? {16'h0, lo} : {half_at(p + 2), lo};
        r1 = resp_at(p);
        r2 = resp_at(p + 2);
        e_resp = r1;
        e_tval = p;
        if (!e_comp && p[2:1] == 2'd3) begin
            e_resp = (r1 != 2'b00) ? r1 : r2;
            e_tval = (r1 != 2'b00) ? p : p + 64'd2;
        end
        if (pc !== p) begin
            $display("ERR pc got %h exp %h", pc, p);
            errs++;
        end
        if (inst !== e_inst) begin
            $display("ERR inst got %h exp %h at pc %h", inst, e_inst, p);
            errs++;
        end
        if (compressed !== e_comp) begin
            $display("ERR compressed got %h exp %h at pc %h", compressed, e_comp, p);
            errs++;
        end
        if (rresp_out !== e_resp) begin
            $display("ERR rresp_out got %h exp %h at pc %h", rresp_out, e_resp, p);
            errs++;
        end
        if (tval !== e_tval) begin
            $display("ERR tval got %h exp %h at pc %h", tval, e_tval, p);
            errs++;
        end
    endtask

    task automatic run_row(input int r);
        ifu_pkg::addr_t start;
        ifu_pkg::addr_t exp_pc;
        int             got;
        int             idle;
        int             errs;
        logic           seen;
        start = row_seek[r] ? find_crossing(row_start[r]) : row_start[r];
        err_word = (row_err[r] == 1) ? ((start + 64'd2) & ~64'd7) :
                   (row_err[r] == 2) ? (start & ~64'd7) : '1;
        lat_rand = row_lat[r];
        errs = 0;
        if (row_reset[r]) begin
            rst_n = 1'b0;
            repeat (8) @(posedge clk);
            #1 rst_n = 1'b1;
        end else begin
            // jump right after an address handshake so its beat is still owed
            inst_ready = 1'b1;
            idle = 0;
            seen = 1'b0;
            while (!seen && idle < 200) begin
                @(posedge clk);
                seen = arvalid && arready;
                idle++;
            end
            if (!seen) begin
                $display("test %0d saw no read request before the jump", r);
                errs++;
            end
            #1;
            jump_flag = 1'b1;
            jump_addr = start;
            @(posedge clk);
            #1 jump_flag = 1'b0;
        end
        exp_pc = start;
        got = 0;
        idle = 0;
        inst_ready = row_rdy[r] ? (($random(seed) & 1) != 0) : 1'b1;
        while (got < row_count[r] && idle < 200) begin
            @(posedge clk);
            if (inst_valid && inst_ready) begin
                check_item(exp_pc, errs);
                exp_pc = exp_pc + ((half_at(exp_pc) & 16'h3) == 16'h3 ? 64'd4 : 64'd2);
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            #1;
            inst_ready = (got < row_count[r]) &&
                         (row_rdy[r] ? (($random(seed) & 1) != 0) : 1'b1);
        end
        if (got < row_count[r]) begin
            $display("test %0d timed out waiting for inst_valid after %0d items", r, got);
            errs++;
        end
        total_err += errs;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("test %0d start %h items %0d errors %0d", r, start, got, errs);
    endtask

    initial begin
        rst_n = 1'b0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = '0;
        jump_flag = 1'b0;
        jump_addr = '0;
        inst_ready = 1'b0;
        load_table();
        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
        end
        $display("tests %0d failed %0d errors %0d", ROWS, failed_tests, total_err);
        if (total_err == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ifu_fetch.f
hdl/ifu_pkg.sv
hdl/fetch_request.sv
hdl/fetch_buffer.sv
hdl/inst_aligner.sv
hdl/decode_queue.sv
hdl/ifu_top.sv
verif/ifu_assertions.sv
verif/ifu_tb.sv

// File: Makefile
# Verilator build and run of the instruction fetch unit testbench

OBJ = obj_dir

all: run

build:
	verilator --binary --timing --assert -f ifu_fetch.f --top-module ifu_tb -Mdir $(OBJ)

run: build
	./$(OBJ)/Vifu_tb | tee sim.log
	grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only -Wall --timing -f ifu_fetch.f --top-module ifu_tb

clean:
	rm -rf $(OBJ) sim.log

.PHONY: all build run lint clean
